//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // byte address and data word widths of the memory bus
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // one strobe per byte lane
    parameter int BE_W = DATA_W / 8;

    // access width of a load or store
    typedef enum logic [1:0] {
        BYTE,
        HALFWORD,
        WORD
    } data_width_e;

endpackage

`default_nettype wire

//--- verilog/data_access_unit.sv
`timescale 1ns/1ps
`default_nettype none

module data_access_unit import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire logic              mem_read_i,
    input  wire logic              mem_write_i,
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic [DATA_W-1:0] wdata_i,
    input  wire data_width_e       width_i,
    output logic      [DATA_W-1:0] rdata_o,
    output logic                   done_o,
    output logic                   bus_read_o,
    output logic                   bus_write_o,
    output logic      [ADDR_W-1:0] bus_addr_o,
    output logic      [DATA_W-1:0] bus_wdata_o,
    output logic      [BE_W-1:0]   bus_be_o,
    input  wire logic              bus_hit_i,
    input  wire logic [DATA_W-1:0] bus_rdata_i
);

    typedef enum logic [1:0] {IDLE, READ, WRITE} state_e;

    state_e            state, next_state;
    logic [DATA_W-1:0] next_rdata;
    logic              next_done;
    logic [DATA_W-1:0] lane_data;   // addressed lane moved down to bit 0

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            rdata_o <= '0;
            done_o  <= 1'b0;
        end else begin
            state   <= next_state;
            rdata_o <= next_rdata;
            done_o  <= next_done;
        end
    end

    assign bus_read_o  = (state == READ);
    assign bus_write_o = (state == WRITE);
    assign bus_addr_o  = {addr_i[ADDR_W-1:2], 2'b00};   // word aligned

    // replicate the store data so every lane carries it, strobes pick one
    always_comb begin
        case (width_i)
            BYTE: begin
                bus_wdata_o = {4{wdata_i[7:0]}};
                bus_be_o    = 4'b0001 << addr_i[1:0];
            end
            HALFWORD: begin
                bus_wdata_o = {2{wdata_i[15:0]}};
                bus_be_o    = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                bus_wdata_o = wdata_i;
                bus_be_o    = 4'b1111;
            end
        endcase
    end

    assign lane_data = bus_rdata_i >> {addr_i[1:0], 3'b000};

    always_comb begin
        next_state = state;
        next_rdata = rdata_o;
        next_done  = 1'b0;
        case (state)
            IDLE: begin
                // no new access in the done cycle, the requester drops then
                if (mem_read_i && !done_o) begin
                    next_state = READ;
                end else if (mem_write_i && !done_o) begin
                    next_state = WRITE;
                end
            end
            READ: begin
                if (bus_hit_i) begin
                    case (width_i)
                        BYTE:     next_rdata = {{24{lane_data[7]}}, lane_data[7:0]};
                        HALFWORD: next_rdata = {{16{lane_data[15]}}, lane_data[15:0]};
                        default:  next_rdata = lane_data;
                    endcase
                    next_done  = 1'b1;
                    next_state = IDLE;
                end
            end
            WRITE: begin
                if (bus_hit_i) begin
                    next_done  = 1'b1;
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire logic              fetch_req_i,
    input  wire logic [ADDR_W-1:0] pc_i,
    output logic      [DATA_W-1:0] instr_o,
    output logic                   instr_valid_o,
    output logic                   bus_read_o,
    output logic      [ADDR_W-1:0] bus_addr_o,
    input  wire logic              bus_hit_i,
    input  wire logic [DATA_W-1:0] bus_rdata_i
);

    typedef enum logic {F_IDLE, F_WAIT} fstate_e;

    fstate_e state;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state         <= F_IDLE;
            instr_o       <= '0;
            instr_valid_o <= 1'b0;
        end else begin
            instr_valid_o <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (fetch_req_i && !instr_valid_o) begin  // held request waits a cycle
                        state <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    if (bus_hit_i) begin
                        instr_o       <= bus_rdata_i;
                        instr_valid_o <= 1'b1;
                        state         <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    assign bus_read_o = (state == F_WAIT);
    assign bus_addr_o = {pc_i[ADDR_W-1:2], 2'b00};

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire logic              d_read_i,
    input  wire logic              d_write_i,
    input  wire logic [ADDR_W-1:0] d_addr_i,
    input  wire logic [DATA_W-1:0] d_wdata_i,
    input  wire logic [BE_W-1:0]   d_be_i,
    output logic                   d_hit_o,
    input  wire logic              f_read_i,
    input  wire logic [ADDR_W-1:0] f_addr_i,
    output logic                   f_hit_o,
    output logic                   mem_read_o,
    output logic                   mem_write_o,
    output logic      [ADDR_W-1:0] mem_addr_o,
    output logic      [DATA_W-1:0] mem_wdata_o,
    output logic      [BE_W-1:0]   mem_be_o,
    input  wire logic              mem_hit_i
);

    typedef enum logic [1:0] {GNT_NONE, GNT_DATA, GNT_FETCH} grant_e;

    grant_e grant;   // locked owner, from acceptance until the hit
    grant_e sel;     // owner of the bus in this cycle
    logic   d_req;

    assign d_req = d_read_i || d_write_i;

    // free bus goes straight to the waiting requester, data first
    always_comb begin
        if (grant != GNT_NONE) begin
            sel = grant;
        end else if (d_req) begin
            sel = GNT_DATA;
        end else if (f_read_i) begin
            sel = GNT_FETCH;
        end else begin
            sel = GNT_NONE;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            grant <= GNT_NONE;
        end else if (mem_hit_i) begin
            grant <= GNT_NONE;
        end else if (grant == GNT_NONE) begin
            grant <= sel;
        end
    end

    always_comb begin
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        mem_addr_o  = d_addr_i;
        mem_wdata_o = d_wdata_i;
        mem_be_o    = d_be_i;
        case (sel)
            GNT_DATA: begin
                mem_read_o  = d_read_i;
                mem_write_o = d_write_i && !d_read_i;   // read wins, as in the requester
            end
            GNT_FETCH: begin
                mem_read_o  = f_read_i;
                mem_addr_o  = f_addr_i;
                mem_wdata_o = '0;
                mem_be_o    = '1;
            end
            default: ;
        endcase
    end

    assign d_hit_o = mem_hit_i && (grant == GNT_DATA);
    assign f_hit_o = mem_hit_i && (grant == GNT_FETCH);

endmodule

`default_nettype wire

//--- verilog/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model import mem_pkg::*; #(
    parameter int MEM_DEPTH   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire logic              mem_read_i,
    input  wire logic              mem_write_i,
    input  wire logic [ADDR_W-1:0] mem_addr_i,
    input  wire logic [DATA_W-1:0] mem_wdata_i,
    input  wire logic [BE_W-1:0]   mem_be_i,
    output logic      [DATA_W-1:0] mem_rdata_o,
    output logic                   mem_hit_o
);

    localparam int IDX_W = $clog2(MEM_DEPTH);
    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic              busy;
    logic [CNT_W-1:0]  cnt;   // cycles left before the hit
    logic              write_q;
    logic [IDX_W-1:0]  idx_q;
    logic [DATA_W-1:0] wdata_q;
    logic [BE_W-1:0]   be_q;

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            busy      <= 1'b0;
            cnt       <= '0;
            mem_hit_o <= 1'b0;
        end else begin
            mem_hit_o <= 1'b0;
            if (busy) begin
                if (cnt == '0) begin
                    busy      <= 1'b0;
                    mem_hit_o <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (!mem_hit_o && (mem_read_i || mem_write_i)) begin
                // the request is still held during the hit cycle, so skip it
                busy <= 1'b1;
                cnt  <= CNT_W'(MEM_LATENCY - 1);
            end
        end
    end

    // request payload, captured on acceptance
    always_ff @(posedge clk) begin
        if (!busy && !mem_hit_o && (mem_read_i || mem_write_i)) begin
            write_q <= mem_write_i && !mem_read_i;
            idx_q   <= mem_addr_i[IDX_W+1:2];
            wdata_q <= mem_wdata_i;
            be_q    <= mem_be_i;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && cnt == '0) begin
            mem_rdata_o <= mem[idx_q];
            if (write_q) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (be_q[b]) mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; #(
    parameter int MEM_DEPTH   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire logic              mem_read_i,
    input  wire logic              mem_write_i,
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic [DATA_W-1:0] wdata_i,
    input  wire data_width_e       width_i,
    output logic      [DATA_W-1:0] rdata_o,
    output logic                   done_o,
    input  wire logic              fetch_req_i,
    input  wire logic [ADDR_W-1:0] pc_i,
    output logic      [DATA_W-1:0] instr_o,
    output logic                   instr_valid_o
);

    // data side
    logic              d_read, d_write, d_hit;
    logic [ADDR_W-1:0] d_addr;
    logic [DATA_W-1:0] d_wdata;
    logic [BE_W-1:0]   d_be;
    // fetch side
    logic              f_read, f_hit;
    logic [ADDR_W-1:0] f_addr;
    // shared memory bus
    logic              mem_read, mem_write, mem_hit;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata, mem_rdata;
    logic [BE_W-1:0]   mem_be;

    data_access_unit i_dau (
        .clk, .nRST, .mem_read_i, .mem_write_i, .addr_i, .wdata_i, .width_i,
        .rdata_o, .done_o,
        .bus_read_o(d_read), .bus_write_o(d_write), .bus_addr_o(d_addr),
        .bus_wdata_o(d_wdata), .bus_be_o(d_be),
        .bus_hit_i(d_hit), .bus_rdata_i(mem_rdata)
    );

    fetch_unit i_fetch (
        .clk, .nRST, .fetch_req_i, .pc_i, .instr_o, .instr_valid_o,
        .bus_read_o(f_read), .bus_addr_o(f_addr),
        .bus_hit_i(f_hit), .bus_rdata_i(mem_rdata)
    );

    mem_arbiter i_arb (
        .clk, .nRST,
        .d_read_i(d_read), .d_write_i(d_write), .d_addr_i(d_addr),
        .d_wdata_i(d_wdata), .d_be_i(d_be), .d_hit_o(d_hit),
        .f_read_i(f_read), .f_addr_i(f_addr), .f_hit_o(f_hit),
        .mem_read_o(mem_read), .mem_write_o(mem_write), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata), .mem_be_o(mem_be), .mem_hit_i(mem_hit)
    );

    sram_model #(
        .MEM_DEPTH  (MEM_DEPTH),
        .MEM_LATENCY(MEM_LATENCY)
    ) i_sram (
        .clk, .nRST,
        .mem_read_i(mem_read), .mem_write_i(mem_write), .mem_addr_i(mem_addr),
        .mem_wdata_i(mem_wdata), .mem_be_i(mem_be),
        .mem_rdata_o(mem_rdata), .mem_hit_o(mem_hit)
    );

endmodule

`default_nettype wire

//--- dv/mem_subsys_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assert import mem_pkg::*; (
    input wire logic              clk,
    input wire logic              nRST,
    input wire logic              mem_read_i,
    input wire logic              mem_write_i,
    input wire logic [ADDR_W-1:0] mem_addr_i,
    input wire logic              mem_hit_i,
    input wire logic              d_hit_i,
    input wire logic              f_hit_i,
    input wire logic              d_req_i,
    input wire logic              f_req_i
);

    logic mem_req;

    assign mem_req = mem_read_i || mem_write_i;

    // the hit goes back only to a requester that still holds its request
    a_one_owner: assert property (@(posedge clk) disable iff (!nRST)
        !(d_hit_i && !d_req_i) && !(f_hit_i && !f_req_i))
        else $error("hit steered to a requester that was not asking");

    a_hit_routed: assert property (@(posedge clk) disable iff (!nRST)
        mem_hit_i |-> (d_hit_i || f_hit_i))
        else $error("memory hit reached no requester");

    // request and address stay put until the memory answers
    a_req_held: assert property (@(posedge clk) disable iff (!nRST)
        (mem_req && !mem_hit_i) |=> (mem_req && $stable(mem_addr_i)))
        else $error("granted request left the bus before its hit");

    a_hit_after_req: assert property (@(posedge clk) disable iff (!nRST)
        mem_hit_i |-> $past(mem_req))
        else $error("hit without a preceding request");

endmodule

`default_nettype wire

//--- dv/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    localparam int MEM_DEPTH   = 256;
    localparam int MEM_LATENCY = 2;
    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 10;
    localparam int N_FIXED     = 13;
    localparam int N_TESTS     = 21;
    localparam int TIMEOUT_NS  = (RST_CYCLES + N_TESTS * 4 * (MEM_LATENCY + 4)) * CLK_PERIOD;

    localparam logic [1:0] OP_NONE  = 2'd0;
    localparam logic [1:0] OP_LOAD  = 2'd1;
    localparam logic [1:0] OP_STORE = 2'd2;

    typedef struct packed {
        logic [1:0]  op;
        data_width_e width;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        fetch;
        logic [31:0] pc;
    } stim_t;

    logic              clk;
    logic              nRST;
    logic              mem_read_i;
    logic              mem_write_i;
    logic [ADDR_W-1:0] addr_i;
    logic [DATA_W-1:0] wdata_i;
    data_width_e       width_i;
    logic [DATA_W-1:0] rdata_o;
    logic              done_o;
    logic              fetch_req_i;
    logic [ADDR_W-1:0] pc_i;
    logic [DATA_W-1:0] instr_o;
    logic              instr_valid_o;

    stim_t       stim [N_TESTS];
    string       stim_name [N_TESTS];
    logic [7:0]  ref_mem [MEM_DEPTH*4];   // byte image of the sram
    logic [31:0] rng;
    int          n_checks;
    int          n_errors;

    mem_subsys_top #(.MEM_DEPTH(MEM_DEPTH), .MEM_LATENCY(MEM_LATENCY)) i_dut (.*);

    bind mem_arbiter mem_subsys_assert i_arb_assert (
        .clk(clk), .nRST(nRST), .mem_read_i(mem_read_o), .mem_write_i(mem_write_o),
        .mem_addr_i(mem_addr_o), .mem_hit_i(mem_hit_i), .d_hit_i(d_hit_o),
        .f_hit_i(f_hit_o), .d_req_i(d_req), .f_req_i(f_read_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int access_bytes(input data_width_e width);
        return (width == BYTE) ? 1 : (width == HALFWORD) ? 2 : 4;
    endfunction

    // first byte of the access wrapped like the sram word index
    function automatic int base_index(input logic [31:0] addr, input int n);
        return int'((addr & ~32'(n - 1)) & 32'(MEM_DEPTH * 4 - 1));
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] addr, input data_width_e width);
        int          n;
        int          base;
        logic [31:0] v;
        n = access_bytes(width);
        base = base_index(addr, n);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[base + i];   // little endian
        end
        if (n < 4 && v[8*n-1]) begin
            v = v | ~((32'd1 << (8 * n)) - 32'd1);
        end
        return v;
    endfunction

    task automatic ref_store(input logic [31:0] addr, input data_width_e width,
                             input logic [31:0] data);
        int n;
        int base;
        n = access_bytes(width);
        base = base_index(addr, n);
        for (int i = 0; i < n; i++) begin
            ref_mem[base + i] = data[8*i +: 8];
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic set_entry(input int idx, input string name, input logic [1:0] op,
                             input data_width_e width, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic fetch,
                             input logic [31:0] pc);
        stim_name[idx] = name;
        stim[idx] = '{op, width, addr, wdata, fetch, pc};
    endtask

    task automatic build_table();
        logic [1:0]  op;
        data_width_e width;
        logic [31:0] addr;
        set_entry(0, "word_store", OP_STORE, WORD, 32'h10, 32'hdeadbeef, 1'b0, 32'h0);
        set_entry(1, "word_load", OP_LOAD, WORD, 32'h10, 32'h0, 1'b0, 32'h0);
        set_entry(2, "word_store_base", OP_STORE, WORD, 32'h20, 32'h11223344, 1'b0, 32'h0);
        set_entry(3, "byte_store_lane1", OP_STORE, BYTE, 32'h21, 32'h123456a5, 1'b0, 32'h0);
        set_entry(4, "half_store_upper", OP_STORE, HALFWORD, 32'h22, 32'habcd8001, 1'b0, 32'h0);
        set_entry(5, "word_load_merged", OP_LOAD, WORD, 32'h20, 32'h0, 1'b0, 32'h0);
        set_entry(6, "fetch_merged", OP_NONE, WORD, 32'h0, 32'h0, 1'b1, 32'h22);
        set_entry(7, "byte_load_neg", OP_LOAD, BYTE, 32'h21, 32'h0, 1'b0, 32'h0);
        set_entry(8, "byte_load_pos", OP_LOAD, BYTE, 32'h20, 32'h0, 1'b0, 32'h0);
        set_entry(9, "half_load_neg", OP_LOAD, HALFWORD, 32'h22, 32'h0, 1'b0, 32'h0);
        set_entry(10, "fetch_alone", OP_NONE, WORD, 32'h0, 32'h0, 1'b1, 32'h13);
        set_entry(11, "load_with_fetch", OP_LOAD, WORD, 32'h20, 32'h0, 1'b1, 32'h10);
        set_entry(12, "store_with_fetch", OP_STORE, BYTE, 32'h12, 32'h7f, 1'b1, 32'h20);
        for (int i = N_FIXED; i < N_TESTS; i++) begin
            rng = xorshift32(rng);
            op = rng[0] ? OP_STORE : OP_LOAD;
            width = (rng[2:1] == 2'd3) ? WORD : data_width_e'(rng[2:1]);
            addr = (32'h40 + {26'd0, rng[8:3]}) & ~32'(access_bytes(width) - 1);
            set_entry(i, $sformatf("random_%0d", i - N_FIXED), op, width, addr,
                      xorshift32(rng), rng[9], 32'h40 + {26'd0, rng[15:10]});
        end
    endtask

    task automatic run_entry(input int idx);
        stim_t       s;
        logic [31:0] exp_data;
        logic [31:0] exp_instr;
        bit          d_seen;
        bit          f_seen;
        int          cyc;
        int          d_cyc;
        int          f_cyc;
        int          pulses;
        int          errs_before;
        s = stim[idx];
        errs_before = n_errors;
        // data wins arbitration, so a store lands before a fetch issued with it
        if (s.op == OP_STORE) ref_store(s.addr, s.width, s.wdata);
        exp_data = ref_load(s.addr, s.width);
        exp_instr = ref_load(s.pc, WORD);
        @(negedge clk);
        addr_i = s.addr;
        wdata_i = s.wdata;
        width_i = s.width;
        pc_i = s.pc;
        mem_read_i = (s.op == OP_LOAD);
        mem_write_i = (s.op == OP_STORE);
        fetch_req_i = s.fetch;
        d_seen = (s.op == OP_NONE);
        f_seen = !s.fetch;
        cyc = 0;
        d_cyc = 0;
        f_cyc = 0;
        pulses = 0;
        while (!(d_seen && f_seen)) begin
            @(negedge clk);
            cyc++;
            if (instr_valid_o) pulses++;
            if (done_o && !d_seen) begin
                d_seen = 1'b1;
                d_cyc = cyc;
                mem_read_i = 1'b0;   // drop on done
                mem_write_i = 1'b0;
                if (s.op == OP_LOAD) check(stim_name[idx], exp_data, rdata_o);
            end
            if (instr_valid_o && !f_seen) begin
                f_seen = 1'b1;
                f_cyc = cyc;
                fetch_req_i = 1'b0;
                check($sformatf("%s instr", stim_name[idx]), exp_instr, instr_o);
            end
        end
        repeat (2) begin   // a stray second pulse shows up here
            @(negedge clk);
            if (instr_valid_o) pulses++;
        end
        if (s.fetch) check($sformatf("%s valid pulses", stim_name[idx]), 32'd1, 32'(pulses));
        if (s.fetch && s.op != OP_NONE) begin
            check($sformatf("%s data first", stim_name[idx]), 32'd1, 32'(d_cyc <= f_cyc));
        end
        if (n_errors == errs_before) begin
            $display("[PASS] %s", stim_name[idx]);
        end else begin
            $display("[DONE] %s with %0d mismatches", stim_name[idx], n_errors - errs_before);
        end
    endtask

    initial begin
        nRST = 1'b0;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        addr_i = '0;
        wdata_i = '0;
        width_i = WORD;
        fetch_req_i = 1'b0;
        pc_i = '0;
        n_checks = 0;
        n_errors = 0;
        rng = 32'h1a048760;
        for (int i = 0; i < MEM_DEPTH * 4; i++) begin
            ref_mem[i] = 8'h00;
        end
        build_table();
        repeat (RST_CYCLES) @(negedge clk);
        nRST = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            run_entry(t);
        end
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, no completion seen from the DUT", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/mem_pkg.sv
verilog/data_access_unit.sv
verilog/fetch_unit.sv
verilog/mem_arbiter.sv
verilog/sram_model.sv
verilog/mem_subsys_top.sv
dv/mem_subsys_assert.sv
dv/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the memory subsystem testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
    -f flist.f -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

# a crash or an assertion stop counts as a failure too
./obj_dir/tb_sim > sim.log 2>&1 || echo "*** TEST FAILED ***" >> sim.log

grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; } \
    || echo "simulation passed"
